// File: cnn_ctrl_pkg.sv
`default_nettype none

package cnn_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and codes
    //////////////////////////////////////////////////////////////////////

    localparam int word_w   = 32;
    localparam int mac_num  = 256;
    localparam int chan_w   = 12;
    localparam int pos_w    = 9;
    localparam int stride_w = 3;

    localparam logic [7:0] inst_compute_code      = 8'd87;
    localparam logic [7:0] inst_write_weight_code = 8'd12;

    // status word values seen by the host
    localparam logic [word_w-1:0] status_done     = word_w'(1);
    localparam logic [word_w-1:0] status_out_done = '1;

    //////////////////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [7:0] {
        op_none         = 8'd0,
        op_compute      = inst_compute_code,
        op_write_weight = inst_write_weight_code
    } opcode_e;

    // one-hot kernel size
    typedef enum logic [4:0] {
        k1 = 5'b00001,
        k2 = 5'b00010,
        k3 = 5'b00100,
        k4 = 5'b01000,
        k5 = 5'b10000
    } kernel_e;

    typedef enum logic [3:0] {
        if_idle,
        if_wait_row1, if_wait_row2, if_wait_row3, if_wait_row4, if_wait_row5,
        if_load_row1, if_load_row2, if_load_row3, if_load_row4, if_load_row5,
        if_compute,
        if_wait_step,
        if_load_step
    } ifmaps_state_e;

    typedef enum logic [4:0] {
        w_idle,
        w_reset_addr,
        w_k1_0,
        w_k2_0, w_k2_1,
        w_k3_0, w_k3_1, w_k3_2,
        w_k4_0, w_k4_1, w_k4_2, w_k4_3,
        w_k5_0, w_k5_1, w_k5_2, w_k5_3, w_k5_4,
        w_load_weight
    } weight_state_e;

    typedef enum logic [1:0] {
        ww_idle,
        ww_start,
        ww_wait,
        ww_finish
    } ww_state_e;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [chan_w-1:0]   input_channels;
        logic [chan_w-1:0]   output_channels;
        logic [pos_w-1:0]    out_width;
        logic [stride_w-1:0] stride;
        kernel_e             kernel;
    } layer_cfg_t;

    typedef struct packed {
        logic write_en;
        logic port_sel;
        logic add1;
        logic add2;
        logic transfer_start;
    } bram_ctrl_t;

endpackage

`default_nettype wire

// File: inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import cnn_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [word_w-1:0]  reg_cmd,
    input  logic [word_w-1:0]  reg_shape,
    input  logic [word_w-1:0]  reg_kernel,
    output layer_cfg_t         layer_cfg,
    output logic               compute_on,
    output logic               write_on,
    output logic               compute_rise,
    output logic               write_rise,
    output logic [mac_num-1:0] mac_enable
);

    opcode_e opcode;
    logic    compute_q;
    logic    write_q;

    // field slicing
    assign opcode                    = opcode_e'(reg_cmd[7:0]);
    assign layer_cfg.input_channels  = reg_cmd[19:8];
    assign layer_cfg.output_channels = reg_cmd[31:20];
    assign layer_cfg.out_width       = reg_shape[10:2];
    assign layer_cfg.stride          = reg_shape[13:11];
    assign layer_cfg.kernel          = kernel_e'(reg_kernel[4:0]);

    assign compute_on = (opcode == op_compute);
    assign write_on   = (opcode == op_write_weight);

    // previous levels for edge detect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compute_q <= 1'b0;
            write_q   <= 1'b0;
        end else begin
            compute_q <= compute_on;
            write_q   <= write_on;
        end
    end

    assign compute_rise = compute_on && !compute_q;
    assign write_rise   = write_on && !write_q;

    // one enable lane per input channel
    always_comb begin
        for (int i = 0; i < mac_num; i++) begin
            mac_enable[i] = (i < layer_cfg.input_channels);
        end
    end

    // sequencers decode the kernel as one-hot
    a_kernel_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        compute_on |-> $onehot(layer_cfg.kernel)
    );

endmodule

`default_nettype wire

// File: ifmaps_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module ifmaps_sequencer import cnn_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       compute_on,
    input  layer_cfg_t layer_cfg,
    input  logic       ifmaps_fifo_empty,
    input  logic       pixel_done,
    output logic       load_ifmaps,
    output logic       in_compute,
    output logic       row_start,
    output logic       layer_last
);

    ifmaps_state_e       state;
    logic [stride_w-1:0] stride_cnt;
    logic [pos_w-1:0]    col_cnt;
    logic [pos_w-1:0]    row_cnt;
    logic                row_end;
    logic                stride_last;
    logic                wait_hold;

    assign wait_hold   = ifmaps_fifo_empty;
    assign stride_last = (stride_w'(stride_cnt + 1'b1) == layer_cfg.stride);

    //////////////////////////////////////////////////////////////////////
    // row and stride load FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= if_idle;
        end else if (!compute_on) begin
            state <= if_idle;
        end else begin
            case (state)
                if_idle:      state <= if_wait_row1;
                if_wait_row1: state <= wait_hold ? if_wait_row1 : if_load_row1;
                if_load_row1: state <= (layer_cfg.kernel == k1) ? if_compute : if_wait_row2;
                if_wait_row2: state <= wait_hold ? if_wait_row2 : if_load_row2;
                if_load_row2: state <= (layer_cfg.kernel == k2) ? if_compute : if_wait_row3;
                if_wait_row3: state <= wait_hold ? if_wait_row3 : if_load_row3;
                if_load_row3: state <= (layer_cfg.kernel == k3) ? if_compute : if_wait_row4;
                if_wait_row4: state <= wait_hold ? if_wait_row4 : if_load_row4;
                if_load_row4: state <= (layer_cfg.kernel == k4) ? if_compute : if_wait_row5;
                if_wait_row5: state <= wait_hold ? if_wait_row5 : if_load_row5;
                if_load_row5: state <= if_compute;
                if_compute: begin
                    if (pixel_done) begin
                        if (layer_last) begin
                            state <= if_idle;
                        end else if (row_end) begin
                            state <= if_wait_row1;
                        end else begin
                            state <= if_wait_step;
                        end
                    end
                end
                if_wait_step: state <= wait_hold ? if_wait_step : if_load_step;
                if_load_step: state <= stride_last ? if_compute : if_wait_step;
                default:      state <= if_idle;
            endcase
        end
    end

    assign load_ifmaps = state inside {if_load_row1, if_load_row2, if_load_row3,
                                       if_load_row4, if_load_row5, if_load_step};
    assign in_compute  = (state == if_compute);

    // stride loads since the last pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stride_cnt <= '0;
        end else if (state == if_load_step) begin
            stride_cnt <= stride_w'(stride_cnt + 1'b1);
        end else if (state == if_compute) begin
            stride_cnt <= '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output position
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (state == if_idle) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (in_compute && pixel_done) begin
            if (row_end) begin
                col_cnt <= '0;
                row_cnt <= pos_w'(row_cnt + 1'b1);
            end else begin
                col_cnt <= pos_w'(col_cnt + 1'b1);
            end
        end
    end

    assign row_end    = (col_cnt == pos_w'(layer_cfg.out_width - 1'b1));
    assign row_start  = (col_cnt == '0);
    assign layer_last = row_end && (row_cnt == pos_w'(layer_cfg.out_width - 1'b1));

    a_no_load_on_empty: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_ifmaps |-> !ifmaps_fifo_empty
    );

endmodule

`default_nettype wire

// File: weight_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module weight_sequencer import cnn_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       compute_on,
    input  logic       in_compute,
    input  layer_cfg_t layer_cfg,
    input  logic       weight_valid,
    output logic       load_weight_preload,
    output logic       load_weight,
    output logic       pixel_done,
    output bram_ctrl_t bram_read
);

    weight_state_e     state;
    logic [chan_w-1:0] filter_cnt;
    logic              last_filter;
    logic              read_step;
    logic              pass_step;
    logic              wide_add1;
    logic              wide_add2;

    // first preload step of a filter for the given kernel
    function automatic weight_state_e first_step(input kernel_e k);
        case (k)
            k2:      return w_k2_0;
            k3:      return w_k3_0;
            k4:      return w_k4_0;
            k5:      return w_k5_0;
            default: return w_k1_0;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // preload FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= w_idle;
        end else if (!compute_on) begin
            state <= w_idle;
        end else begin
            case (state)
                w_idle:        state <= in_compute ? w_reset_addr : w_idle;
                w_reset_addr:  state <= first_step(layer_cfg.kernel);
                w_k1_0:        state <= weight_valid ? w_load_weight : w_k1_0;
                w_k2_0:        state <= weight_valid ? w_k2_1 : w_k2_0;
                w_k2_1:        state <= w_load_weight;
                w_k3_0:        state <= weight_valid ? w_k3_1 : w_k3_0;
                w_k3_1:        state <= w_k3_2;
                w_k3_2:        state <= weight_valid ? w_load_weight : w_k3_2;
                w_k4_0:        state <= weight_valid ? w_k4_1 : w_k4_0;
                w_k4_1:        state <= w_k4_2;
                w_k4_2:        state <= weight_valid ? w_k4_3 : w_k4_2;
                w_k4_3:        state <= w_load_weight;
                w_k5_0:        state <= weight_valid ? w_k5_1 : w_k5_0;
                w_k5_1:        state <= w_k5_2;
                w_k5_2:        state <= weight_valid ? w_k5_3 : w_k5_2;
                w_k5_3:        state <= w_k5_4;
                w_k5_4:        state <= weight_valid ? w_load_weight : w_k5_4;
                w_load_weight: state <= last_filter ? w_idle : first_step(layer_cfg.kernel);
                default:       state <= w_idle;
            endcase
        end
    end

    // read steps wait on the BRAM, pass steps take the other port
    assign read_step = state inside {w_k1_0, w_k2_0, w_k3_0, w_k3_2, w_k4_0,
                                     w_k4_2, w_k5_0, w_k5_2, w_k5_4};
    assign pass_step = state inside {w_k2_1, w_k3_1, w_k4_1, w_k4_3, w_k5_1, w_k5_3};

    assign load_weight_preload = (read_step && weight_valid) || pass_step;
    assign load_weight         = (state == w_load_weight);

    //////////////////////////////////////////////////////////////////////
    // filter count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filter_cnt <= '0;
        end else if (state == w_idle) begin
            filter_cnt <= '0;
        end else if (load_weight) begin
            filter_cnt <= chan_w'(filter_cnt + 1'b1);
        end
    end

    assign last_filter = (chan_w'(filter_cnt + 1'b1) == layer_cfg.output_channels);
    assign pixel_done  = load_weight && last_filter;

    // address strobes
    assign wide_add1 = (load_weight && layer_cfg.kernel inside {k1, k5})
                       || state inside {w_k3_2, w_k5_4};
    assign wide_add2 = (load_weight && layer_cfg.kernel inside {k2, k4})
                       || state inside {w_k3_1, w_k4_0, w_k5_0, w_k5_2};

    assign bram_read = '{
        write_en:       1'b0,
        port_sel:       pass_step,
        add1:           weight_valid && wide_add1,
        add2:           weight_valid && wide_add2,
        transfer_start: (state == w_reset_addr)
    };

    a_load_not_with_preload: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_weight && load_weight_preload)
    );

endmodule

`default_nettype wire

// File: host_status.sv
`timescale 1ns/100ps
`default_nettype none

module host_status import cnn_ctrl_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              write_on,
    input  logic              compute_rise,
    input  logic              write_rise,
    input  logic              write_weight_finish,
    input  logic              output_finish,
    input  logic              pixel_done,
    input  logic              layer_last,
    input  bram_ctrl_t        bram_read,
    output bram_ctrl_t        bram_ctrl,
    output logic              axis_en,
    output logic              axis_clear,
    output logic              layer_finish,
    output logic [word_w-1:0] reg_status
);

    ww_state_e ww_state;
    logic      layer_end;
    logic      inst_rise;
    logic      clear_q;

    assign layer_end = pixel_done && layer_last;
    assign inst_rise = compute_rise || write_rise;

    //////////////////////////////////////////////////////////////////////
    // weight write FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ww_state <= ww_idle;
        end else if (!write_on) begin
            ww_state <= ww_idle;
        end else begin
            case (ww_state)
                ww_idle:   ww_state <= ww_start;
                ww_start:  ww_state <= ww_wait;
                ww_wait:   ww_state <= write_weight_finish ? ww_finish : ww_wait;
                ww_finish: ww_state <= ww_finish;
                default:   ww_state <= ww_idle;
            endcase
        end
    end

    // read strobes pass through, write side merged in
    assign bram_ctrl = '{
        write_en:       (ww_state != ww_idle),
        port_sel:       bram_read.port_sel,
        add1:           bram_read.add1,
        add2:           bram_read.add2,
        transfer_start: bram_read.transfer_start || (ww_state == ww_start)
    };

    //////////////////////////////////////////////////////////////////////
    // stream levels and status
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axis_en <= 1'b0;
            clear_q <= 1'b0;
        end else begin
            clear_q <= write_weight_finish;
            if (layer_end || write_weight_finish) begin
                axis_en <= 1'b0;
            end else if (inst_rise) begin
                axis_en <= 1'b1;
            end
        end
    end

    assign axis_clear   = clear_q || compute_rise;
    assign layer_finish = layer_end;

    // write finish wins over output finish, clear is last
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_status <= '0;
        end else if (write_weight_finish) begin
            reg_status <= status_done;
        end else if (output_finish) begin
            reg_status <= status_out_done;
        end else if (inst_rise) begin
            reg_status <= '0;
        end
    end

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit import cnn_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [word_w-1:0]  reg_cmd,
    input  logic [word_w-1:0]  reg_shape,
    input  logic [word_w-1:0]  reg_kernel,
    input  logic               ifmaps_fifo_empty,
    input  logic               weight_valid,
    input  logic               write_weight_finish,
    input  logic               output_finish,
    output layer_cfg_t         layer_cfg,
    output logic [mac_num-1:0] mac_enable,
    output logic               load_ifmaps,
    output logic               load_weight_preload,
    output logic               load_weight,
    output bram_ctrl_t         bram_ctrl,
    output logic               axis_en,
    output logic               axis_clear,
    output logic               layer_finish,
    output logic [word_w-1:0]  reg_status
);

    logic       compute_on;
    logic       write_on;
    logic       compute_rise;
    logic       write_rise;
    logic       in_compute;
    logic       layer_last;
    logic       pixel_done;
    bram_ctrl_t bram_read;

    inst_decoder i_inst_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .reg_cmd      (reg_cmd),
        .reg_shape    (reg_shape),
        .reg_kernel   (reg_kernel),
        .layer_cfg    (layer_cfg),
        .compute_on   (compute_on),
        .write_on     (write_on),
        .compute_rise (compute_rise),
        .write_rise   (write_rise),
        .mac_enable   (mac_enable)
    );

    // row_start stays inside the sequencer
    ifmaps_sequencer i_ifmaps_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .compute_on        (compute_on),
        .layer_cfg         (layer_cfg),
        .ifmaps_fifo_empty (ifmaps_fifo_empty),
        .pixel_done        (pixel_done),
        .load_ifmaps       (load_ifmaps),
        .in_compute        (in_compute),
        .row_start         (),
        .layer_last        (layer_last)
    );

    weight_sequencer i_weight_sequencer (
        .clk                 (clk),
        .rst_n               (rst_n),
        .compute_on          (compute_on),
        .in_compute          (in_compute),
        .layer_cfg           (layer_cfg),
        .weight_valid        (weight_valid),
        .load_weight_preload (load_weight_preload),
        .load_weight         (load_weight),
        .pixel_done          (pixel_done),
        .bram_read           (bram_read)
    );

    host_status i_host_status (
        .clk                 (clk),
        .rst_n               (rst_n),
        .write_on            (write_on),
        .compute_rise        (compute_rise),
        .write_rise          (write_rise),
        .write_weight_finish (write_weight_finish),
        .output_finish       (output_finish),
        .pixel_done          (pixel_done),
        .layer_last          (layer_last),
        .bram_read           (bram_read),
        .bram_ctrl           (bram_ctrl),
        .axis_en             (axis_en),
        .axis_clear          (axis_clear),
        .layer_finish        (layer_finish),
        .reg_status          (reg_status)
    );

endmodule

`default_nettype wire

// File: tb_control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_control_unit import cnn_ctrl_pkg::*; ;

    localparam int clk_period = 8;
    localparam int seed       = 7;
    localparam int num_rows   = 6;

    // conv rows expect load_ifmaps, load_weight, load_weight_preload counts;
    // weight write rows expect transfer_start pulses, axis_clear pulses, status
    typedef struct packed {
        logic [7:0] op;
        int         k;
        int         stride;
        int         width;
        int         in_ch;
        int         out_ch;
        int         exp_a;
        int         exp_b;
        int         exp_c;
    } test_row_t;

    logic               clk;
    logic               rst_n;
    logic [word_w-1:0]  reg_cmd;
    logic [word_w-1:0]  reg_shape;
    logic [word_w-1:0]  reg_kernel;
    logic               ifmaps_fifo_empty;
    logic               weight_valid;
    logic               write_weight_finish;
    logic               output_finish;
    layer_cfg_t         layer_cfg;
    logic [mac_num-1:0] mac_enable;
    logic               load_ifmaps;
    logic               load_weight_preload;
    logic               load_weight;
    bram_ctrl_t         bram_ctrl;
    logic               axis_en;
    logic               axis_clear;
    logic               layer_finish;
    logic [word_w-1:0]  reg_status;

    test_row_t   table_rows [num_rows];
    int          errors;
    int          tests_passed;
    int          tests_failed;
    int          watchdog_cycles;
    int          stall_cycles;
    int          err_mark;
    int          fifo_count;
    int          fifo_next;
    int unsigned seed_val;
    logic        load_seen = 1'b0;

    control_unit i_control_unit (
        .clk                 (clk),
        .rst_n               (rst_n),
        .reg_cmd             (reg_cmd),
        .reg_shape           (reg_shape),
        .reg_kernel          (reg_kernel),
        .ifmaps_fifo_empty   (ifmaps_fifo_empty),
        .weight_valid        (weight_valid),
        .write_weight_finish (write_weight_finish),
        .output_finish       (output_finish),
        .layer_cfg           (layer_cfg),
        .mac_enable          (mac_enable),
        .load_ifmaps         (load_ifmaps),
        .load_weight_preload (load_weight_preload),
        .load_weight         (load_weight),
        .bram_ctrl           (bram_ctrl),
        .axis_en             (axis_en),
        .axis_clear          (axis_clear),
        .layer_finish        (layer_finish),
        .reg_status          (reg_status)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // FIFO and BRAM stand-ins
    //////////////////////////////////////////////////////////////////////

    always @(negedge clk) load_seen <= load_ifmaps;

    // FIFO only goes empty after a pop, rows trickle in at random
    initial begin
        ifmaps_fifo_empty = 1'b1;
        weight_valid      = 1'b0;
        fifo_count        = 0;
        seed_val          = $urandom(seed);
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                fifo_count        <= 0;
                ifmaps_fifo_empty <= 1'b1;
                weight_valid      <= 1'b0;
            end else begin
                fifo_next = fifo_count + ((($urandom % 4) == 0) ? 1 : 0);
                if (load_seen && fifo_next > 0) begin
                    fifo_next = fifo_next - 1;
                end
                if (fifo_next > 4) begin
                    fifo_next = 4;
                end
                fifo_count        <= fifo_next;
                ifmaps_fifo_empty <= (fifo_next == 0);
                weight_valid      <= (($urandom % 2) == 1);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    function automatic test_row_t make_row(input logic [7:0] op, input int k, input int s,
                                           input int w, input int ic, input int oc,
                                           input int ea, input int eb, input int ec);
        test_row_t r;
        r.op = op;
        r.k = k;
        r.stride = s;
        r.width = w;
        r.in_ch = ic;
        r.out_ch = oc;
        r.exp_a = ea;
        r.exp_b = eb;
        r.exp_c = ec;
        return r;
    endfunction

    function automatic int row_budget(input test_row_t r);
        if (r.op == inst_compute_code) begin
            return 40 * (r.exp_a + r.exp_b + r.exp_c) + 100;
        end
        return 100;
    endfunction

    // mask with the low n lanes set
    function automatic logic [mac_num-1:0] lanes_below(input int n);
        logic [mac_num:0] one;
        logic [mac_num:0] mask;
        one  = 1;
        mask = (one << n) - 1'b1;
        return mask[mac_num-1:0];
    endfunction

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic close_test(input string name, input int mark);
        if (errors == mark) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - mark);
        end
    endtask

    task automatic apply_cmd(input test_row_t r);
        @(posedge clk);
        reg_cmd    <= (word_w'(r.out_ch) << 20) | (word_w'(r.in_ch) << 8) | word_w'(r.op);
        reg_shape  <= (word_w'(r.stride) << 11) | (word_w'(r.width) << 2);
        reg_kernel <= word_w'(1) << (r.k - 1);
    endtask

    task automatic write_weights(input test_row_t r);
        int   starts;
        int   clears;
        logic started;
        starts  = 0;
        clears  = 0;
        started = 1'b0;
        apply_cmd(r);
        repeat (6) begin
            @(negedge clk);
            if (bram_ctrl.transfer_start) begin
                starts++;
                started = 1'b1;
            end
            if (started && !bram_ctrl.write_en) flag_mismatch("write_en low after start");
        end
        @(posedge clk);
        write_weight_finish <= 1'b1;
        @(posedge clk);
        write_weight_finish <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            if (axis_clear) clears++;
            if (!bram_ctrl.write_en) flag_mismatch("write_en dropped before level");
        end
        if (starts != r.exp_a) flag_mismatch($sformatf("transfer_start %0d pulses", starts));
        if (clears != r.exp_b) flag_mismatch($sformatf("axis_clear %0d pulses", clears));
        if (reg_status != word_w'(r.exp_c)) flag_mismatch($sformatf("status %h", reg_status));
        if (axis_en) flag_mismatch("axis_en still high after write finish");
        @(posedge clk);
        reg_cmd <= '0;
        repeat (2) @(negedge clk);
        if (bram_ctrl.write_en) flag_mismatch("write_en high after level dropped");
    endtask

    task automatic convolve_layer(input test_row_t r, input int idx);
        int   loads;
        int   weights;
        int   preloads;
        int   finishes;
        int   cycles;
        int   budget;
        int   tail;
        logic done;
        loads    = 0;
        weights  = 0;
        preloads = 0;
        finishes = 0;
        cycles   = 0;
        tail     = 0;
        done     = 1'b0;
        budget   = row_budget(r);
        apply_cmd(r);
        // count strobes mid-cycle until the layer ends, then a few cycles more
        while (tail < 4) begin
            @(negedge clk);
            if (cycles == 0) begin
                if (mac_enable != lanes_below(r.in_ch)) begin
                    flag_mismatch($sformatf("mac_enable has %0d lanes",
                                            $countones(mac_enable)));
                end
                if (layer_cfg.input_channels != chan_w'(r.in_ch) ||
                    layer_cfg.output_channels != chan_w'(r.out_ch) ||
                    layer_cfg.out_width != pos_w'(r.width) ||
                    layer_cfg.stride != stride_w'(r.stride) ||
                    layer_cfg.kernel != 5'(1 << (r.k - 1))) begin
                    flag_mismatch("layer_cfg does not match the control words");
                end
            end
            if (ifmaps_fifo_empty) stall_cycles++;
            if (load_ifmaps && ifmaps_fifo_empty) flag_mismatch("load_ifmaps on empty FIFO");
            if (load_ifmaps) loads++;
            if (load_weight) weights++;
            if (load_weight_preload) preloads++;
            if (layer_finish) finishes++;
            cycles++;
            if (done) begin
                tail++;
            end else if (layer_finish || cycles >= budget) begin
                done = 1'b1;
                if (!layer_finish) begin
                    report_problem($sformatf("row %0d never finished within %0d cycles", idx,
                                             budget));
                end
                @(posedge clk);
                reg_cmd <= '0;
            end
        end
        if (loads != r.exp_a) flag_mismatch($sformatf("load_ifmaps count %0d", loads));
        if (weights != r.exp_b) flag_mismatch($sformatf("load_weight count %0d", weights));
        if (preloads != r.exp_c) flag_mismatch($sformatf("preload count %0d", preloads));
        if (finishes != 1) flag_mismatch($sformatf("layer_finish %0d pulses", finishes));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst_n               = 1'b0;
        reg_cmd             = '0;
        reg_shape           = '0;
        reg_kernel          = '0;
        write_weight_finish = 1'b0;
        output_finish       = 1'b0;
        errors              = 0;
        tests_passed        = 0;
        tests_failed        = 0;
        stall_cycles        = 0;
        watchdog_cycles     = 0;

        table_rows[0] = make_row(inst_write_weight_code, 1, 1, 1, 0, 0, 1, 1, 1);
        table_rows[1] = make_row(inst_compute_code, 1, 1, 3, 5, 2, 9, 18, 18);
        table_rows[2] = make_row(inst_compute_code, 2, 1, 2, 16, 3, 6, 12, 24);
        table_rows[3] = make_row(inst_compute_code, 3, 2, 3, 1, 2, 21, 18, 54);
        table_rows[4] = make_row(inst_compute_code, 4, 1, 2, 100, 1, 10, 4, 16);
        table_rows[5] = make_row(inst_compute_code, 5, 3, 2, 256, 2, 16, 8, 40);
        for (int i = 0; i < num_rows; i++) begin
            watchdog_cycles += row_budget(table_rows[i]);
        end
        watchdog_cycles += 300;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        err_mark = errors;
        @(negedge clk);
        if (load_ifmaps || load_weight || load_weight_preload || layer_finish) begin
            flag_mismatch("strobe high after reset");
        end
        if (bram_ctrl != '0 || axis_en || axis_clear) flag_mismatch("control high after reset");
        if (reg_status != '0) flag_mismatch($sformatf("status %h after reset", reg_status));
        close_test("reset", err_mark);

        for (int i = 0; i < num_rows; i++) begin
            err_mark = errors;
            if (table_rows[i].op == inst_compute_code) begin
                convolve_layer(table_rows[i], i);
                close_test($sformatf("row %0d conv k%0d", i, table_rows[i].k), err_mark);
            end else begin
                write_weights(table_rows[i]);
                close_test($sformatf("row %0d weight write", i), err_mark);
            end
        end

        // output finish sets all ones, the next instruction clears it
        err_mark = errors;
        @(posedge clk);
        output_finish <= 1'b1;
        @(posedge clk);
        output_finish <= 1'b0;
        @(negedge clk);
        if (reg_status != '1) flag_mismatch($sformatf("status %h after output", reg_status));
        @(posedge clk);
        reg_cmd <= word_w'(inst_write_weight_code);
        repeat (2) @(negedge clk);
        if (reg_status != '0) flag_mismatch($sformatf("status %h after rise", reg_status));
        @(posedge clk);
        reg_cmd <= '0;
        repeat (3) @(negedge clk);
        close_test("status word", err_mark);

        err_mark = errors;
        if (stall_cycles == 0) report_problem("the FIFO stand-in never stalled a convolution");
        close_test($sformatf("FIFO stalls (%0d stall cycles)", stall_cycles), err_mark);

        $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed,
                 tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: run did not complete within %0d cycles", watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
cnn_ctrl_pkg.sv
inst_decoder.sv
ifmaps_sequencer.sv
weight_sequencer.sv
host_status.sv
control_unit.sv
tb_control_unit.sv
